// ==== hdl/bp_cfg_pkg.sv ====
package bp_cfg_pkg;

  // ------------------------------------------------------------
  // address and fetch geometry
  // ------------------------------------------------------------

  // virtual address width
  localparam int VADDR_W = 32;

  // bytes in one fetch block
  localparam int FETCH_BYTES = 8;

  // one bank per halfword slot of a fetch block
  localparam int SLOT_CNT = FETCH_BYTES / 2;
  localparam int SLOT_W   = $clog2(SLOT_CNT);

  // ------------------------------------------------------------
  // derived pc field positions
  // ------------------------------------------------------------

  // lowest pc bit of the halfword offset
  localparam int HW_LSB = 1;

  // lowest pc bit above the block offset
  localparam int BLK_LSB = $clog2(FETCH_BYTES);

  // block address width, i.e. pc bits above the slot field
  // index and tag are both sliced from this, depending on BTB_ENTRIES
  localparam int BLK_W = VADDR_W - BLK_LSB;

endpackage

// ==== hdl/bp_types_pkg.sv ====
package bp_types_pkg;

  import bp_cfg_pkg::*;

  // branch kind as reported by the back end
  typedef enum logic [1:0] {
    BR_COND = 2'd0,
    BR_JUMP = 2'd1,
    BR_CALL = 2'd2,
    BR_RET  = 2'd3
  } br_kind_e;

  // resolved branch from the back end
  typedef struct packed {
    logic                valid;
    logic [VADDR_W-1:0]  pc;
    logic                is_rvc;
    br_kind_e            kind;
    logic [VADDR_W-1:0]  target;
  } btb_update_t;

  // contents of one bank entry
  // tag holds the whole block address of the original pc
  typedef struct packed {
    logic [BLK_W-1:0]    tag;
    br_kind_e            kind;
    logic [VADDR_W-1:0]  target;
  } btb_entry_t;

  // decoded write, index holds the corrected block address
  typedef struct packed {
    logic                valid;
    logic [SLOT_W-1:0]   slot;
    logic [BLK_W-1:0]    index;
    btb_entry_t          entry;
  } btb_write_t;

  // fetch side search request
  typedef struct packed {
    logic                valid;
    logic [VADDR_W-1:0]  pc;
  } btb_search_t;

  // stage 2 prediction
  typedef struct packed {
    logic                valid;
    logic                hit;
    logic [SLOT_W-1:0]   slot;
    br_kind_e            kind;
    logic [VADDR_W-1:0]  target;
  } bp_pred_t;

endpackage

// ==== hdl/data_array_2p.sv ====
`timescale 1ns/1ps

module data_array_2p #(
  parameter int WIDTH  = 32,
  parameter int ADDR_W = 4
) (
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_wr,
  input  logic [ADDR_W-1:0] i_wr_addr,
  input  logic [WIDTH-1:0]  i_wr_data,

  input  logic [ADDR_W-1:0] i_rd_addr,
  output logic [WIDTH-1:0]  o_rd_data
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [WIDTH-1:0] r_mem [DEPTH];

  // write port
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_mem[i_wr_addr] <= i_wr_data;
    end
  end

  // registered read, same-address collision sees the old word
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rd_data <= '0;
    end else begin
      o_rd_data <= r_mem[i_rd_addr];
    end
  end

endmodule

// ==== hdl/btb_update_decode.sv ====
`timescale 1ns/1ps

module btb_update_decode
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
#(
  parameter int SLOT_CNT = bp_cfg_pkg::SLOT_CNT
) (
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  btb_update_t i_upd,
  output btb_write_t  o_wr
);

  localparam int OFS_MSB = HW_LSB + $clog2(SLOT_CNT) - 1;

  logic [VADDR_W-1:HW_LSB] w_hw_pc;
  btb_entry_t              w_entry;

  logic                    r_valid;
  logic [SLOT_W-1:0]       r_slot;
  logic [BLK_W-1:0]        r_index;
  btb_entry_t              r_entry;

  // a 4-byte branch may straddle the block boundary, so it is
  // recorded against its upper halfword
  assign w_hw_pc = i_upd.pc[VADDR_W-1:HW_LSB] + (VADDR_W-HW_LSB)'(!i_upd.is_rvc);

  // tag always from the unmodified pc
  assign w_entry.tag    = i_upd.pc[VADDR_W-1:BLK_LSB];
  assign w_entry.kind   = i_upd.kind;
  assign w_entry.target = i_upd.target;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_upd.valid;
    end
  end

  // payload only captured for a valid update
  always_ff @(posedge i_clk) begin
    if (i_upd.valid) begin
      r_slot  <= w_hw_pc[OFS_MSB:HW_LSB];
      r_index <= w_hw_pc[VADDR_W-1:BLK_LSB];
      r_entry <= w_entry;
    end
  end

  always_comb begin
    o_wr.valid = r_valid;
    o_wr.slot  = r_slot;
    o_wr.index = r_index;
    o_wr.entry = r_entry;
  end

endmodule

// ==== hdl/btb_lookup.sv ====
`timescale 1ns/1ps

module btb_lookup
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
#(
  parameter int BTB_ENTRIES = 16,
  parameter int SLOT_CNT    = bp_cfg_pkg::SLOT_CNT
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  btb_write_t                i_wr,
  input  btb_search_t               i_search,

  output logic                      o_s1_valid,
  output logic [SLOT_CNT-1:0]       o_s1_hit,
  output btb_entry_t [SLOT_CNT-1:0] o_s1_entry
);

  localparam int IDX_W   = $clog2(BTB_ENTRIES);
  localparam int OFS_MSB = HW_LSB + $clog2(SLOT_CNT) - 1;
  // first pc bit of the compared tag
  localparam int TAG_LSB = BLK_LSB + IDX_W;

  logic [IDX_W-1:0]         w_wr_idx;
  logic [IDX_W-1:0]         w_rd_idx;
  logic [SLOT_CNT-1:0]      w_s0_mask;

  logic                     r_s1_valid;
  logic [VADDR_W-1:TAG_LSB] r_s1_tag;
  logic [SLOT_CNT-1:0]      r_s1_mask;

  assign w_wr_idx = i_wr.index[IDX_W-1:0];
  assign w_rd_idx = i_search.pc[TAG_LSB-1:BLK_LSB];

  // slots below the fetch offset are never candidates
  always_comb begin
    for (int s = 0; s < SLOT_CNT; s++) begin
      w_s0_mask[s] = (s >= i_search.pc[OFS_MSB:HW_LSB]);
    end
  end

  // ------------------------------------------------------------
  // s0 -> s1 search registers
  // ------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_search.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_tag  <= i_search.pc[VADDR_W-1:TAG_LSB];
    r_s1_mask <= w_s0_mask;
  end

  assign o_s1_valid = r_s1_valid;

  // ------------------------------------------------------------
  // one bank per halfword slot
  // ------------------------------------------------------------

  for (genvar s = 0; s < SLOT_CNT; s++) begin : g_slot
    logic                   w_bank_wr;
    btb_entry_t             w_rd_entry;
    logic [BTB_ENTRIES-1:0] r_valids;
    logic                   r_s1_entry_vld;

    assign w_bank_wr = i_wr.valid & (i_wr.slot == s);

    data_array_2p #(
      .WIDTH  ($bits(btb_entry_t)),
      .ADDR_W (IDX_W)
    ) u_bank (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_bank_wr),
      .i_wr_addr (w_wr_idx),
      .i_wr_data (i_wr.entry),
      .i_rd_addr (w_rd_idx),
      .o_rd_data (w_rd_entry)
    );

    // valid bits follow the same read-before-write timing as the bank
    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valids       <= '0;
        r_s1_entry_vld <= 1'b0;
      end else begin
        if (w_bank_wr) begin
          r_valids[w_wr_idx] <= 1'b1;
        end
        r_s1_entry_vld <= r_valids[w_rd_idx];
      end
    end

    assign o_s1_entry[s] = w_rd_entry;
    assign o_s1_hit[s]   = r_s1_valid & r_s1_entry_vld & r_s1_mask[s] &
                           (w_rd_entry.tag[BLK_W-1:IDX_W] == r_s1_tag);
  end

endmodule

// ==== hdl/fetch_target_select.sv ====
`timescale 1ns/1ps

module fetch_target_select
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
#(
  parameter int SLOT_CNT = bp_cfg_pkg::SLOT_CNT
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  input  logic                      i_s1_valid,
  input  logic [SLOT_CNT-1:0]       i_s1_hit,
  input  btb_entry_t [SLOT_CNT-1:0] i_s1_entry,

  output bp_pred_t                  o_pred
);

  logic              w_any_hit;
  logic [SLOT_W-1:0] w_sel_slot;
  btb_entry_t        w_sel_entry;

  assign w_any_hit = |i_s1_hit;

  // ------------------------------------------------------------
  // lowest hit wins
  // ------------------------------------------------------------

  // walk from the top slot down so the lowest hit is taken last
  // with no hit the defaults keep slot, kind and target at zero
  always_comb begin
    w_sel_slot  = '0;
    w_sel_entry = '0;
    for (int s = SLOT_CNT - 1; s >= 0; s--) begin
      if (i_s1_hit[s]) begin
        w_sel_slot  = SLOT_W'(s);
        w_sel_entry = i_s1_entry[s];
      end
    end
  end

  // ------------------------------------------------------------
  // stage 2 prediction register
  // ------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_pred <= '0;
    end else begin
      o_pred.valid  <= i_s1_valid;
      o_pred.hit    <= w_any_hit;
      o_pred.slot   <= w_sel_slot;
      o_pred.kind   <= w_sel_entry.kind;
      o_pred.target <= w_sel_entry.target;
    end
  end

endmodule

// ==== hdl/bp_top.sv ====
`timescale 1ns/1ps

module bp_top
  import bp_types_pkg::*;
#(
  parameter int BTB_ENTRIES = 16,
  parameter int SLOT_CNT    = bp_cfg_pkg::SLOT_CNT
) (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  btb_update_t         i_upd,
  input  btb_search_t         i_search,

  output logic [SLOT_CNT-1:0] o_s1_hit,
  output bp_pred_t            o_pred
);

  btb_write_t                w_wr;
  logic                      w_s1_valid;
  btb_entry_t [SLOT_CNT-1:0] w_s1_entry;

  // update side
  btb_update_decode #(
    .SLOT_CNT (SLOT_CNT)
  ) u_decode (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_upd     (i_upd),
    .o_wr      (w_wr)
  );

  // banks and stage 1 hit vector
  btb_lookup #(
    .BTB_ENTRIES (BTB_ENTRIES),
    .SLOT_CNT    (SLOT_CNT)
  ) u_lookup (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wr       (w_wr),
    .i_search   (i_search),
    .o_s1_valid (w_s1_valid),
    .o_s1_hit   (o_s1_hit),
    .o_s1_entry (w_s1_entry)
  );

  // stage 2 prediction
  fetch_target_select #(
    .SLOT_CNT (SLOT_CNT)
  ) u_select (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_s1_valid (w_s1_valid),
    .i_s1_hit   (o_s1_hit),
    .i_s1_entry (w_s1_entry),
    .o_pred     (o_pred)
  );

endmodule

// ==== dv/bp_top_asserts.sv ====
`timescale 1ns/1ps

module bp_top_asserts
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
#(
  parameter int SLOT_CNT = bp_cfg_pkg::SLOT_CNT
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  btb_search_t         i_search,
  input  logic [SLOT_CNT-1:0] i_s1_hit,
  input  bp_pred_t            i_pred
);

  localparam int OFS_MSB = HW_LSB + $clog2(SLOT_CNT) - 1;

  // failed assertions, read by the testbench at the end of the run
  int fail_count = 0;

  a_hit_has_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pred.hit |-> i_pred.valid)
  else begin
    $error("prediction hit without prediction valid");
    fail_count++;
  end

  // slots below the offset of the search one cycle back must stay clear
  a_no_hit_below_ofs: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_s1_hit & ((SLOT_CNT'(1) << $past(i_search.pc[OFS_MSB:HW_LSB])) - SLOT_CNT'(1)))
      == '0)
  else begin
    $error("stage 1 hit below the fetch offset");
    fail_count++;
  end

  a_pred_valid_follows: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pred.valid == $past(i_search.valid, 2))
  else begin
    $error("prediction valid does not follow search valid by two cycles");
    fail_count++;
  end

endmodule

bind bp_top bp_top_asserts #(
  .SLOT_CNT (SLOT_CNT)
) u_asserts (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_search  (i_search),
  .i_s1_hit  (o_s1_hit),
  .i_pred    (o_pred)
);

// ==== dv/bp_checker.sv ====
`timescale 1ns/1ps

module bp_checker
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
#(
  parameter int BTB_ENTRIES = 16,
  parameter int SLOT_CNT    = bp_cfg_pkg::SLOT_CNT
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  btb_update_t         i_upd,
  input  btb_search_t         i_search,
  input  logic [SLOT_CNT-1:0] i_s1_hit,
  input  bp_pred_t            i_pred,
  output int                  o_checks,
  output int                  o_errors
);

  localparam int TAG_SHIFT = BLK_LSB + $clog2(BTB_ENTRIES);

  // reference copy of every bank
  logic               m_valid  [SLOT_CNT][BTB_ENTRIES];
  logic [VADDR_W-1:0] m_tag    [SLOT_CNT][BTB_ENTRIES];
  br_kind_e           m_kind   [SLOT_CNT][BTB_ENTRIES];
  logic [VADDR_W-1:0] m_target [SLOT_CNT][BTB_ENTRIES];

  btb_update_t         pend_upd;
  logic [SLOT_CNT-1:0] exp_hit;
  bp_pred_t            exp_s1_pred;
  bp_pred_t            exp_s2_pred;
  logic                armed;

  // 4-byte branches are filed under their upper halfword
  task automatic apply_write(input btb_update_t u);
    logic [VADDR_W-1:0] corr;
    int                 s;
    int                 idx;
    corr = u.pc + (u.is_rvc ? 32'd0 : 32'd2);
    s    = int'((corr % FETCH_BYTES) >> 1);
    idx  = int'((corr >> BLK_LSB) % BTB_ENTRIES);
    m_valid[s][idx]  = 1'b1;
    m_tag[s][idx]    = u.pc >> TAG_SHIFT;
    m_kind[s][idx]   = u.kind;
    m_target[s][idx] = u.target;
  endtask

  task automatic predict_search(input btb_search_t q);
    int                 ofs;
    int                 idx;
    logic [VADDR_W-1:0] tag;
    ofs = int'((q.pc % FETCH_BYTES) >> 1);
    idx = int'((q.pc >> BLK_LSB) % BTB_ENTRIES);
    tag = q.pc >> TAG_SHIFT;
    exp_hit = '0;
    exp_s1_pred = '0;
    exp_s1_pred.valid = q.valid;
    for (int s = 0; s < SLOT_CNT; s++) begin
      exp_hit[s] = q.valid && m_valid[s][idx] && (m_tag[s][idx] == tag) && (s >= ofs);
      if (exp_hit[s] && !exp_s1_pred.hit) begin
        exp_s1_pred.hit    = 1'b1;
        exp_s1_pred.slot   = SLOT_W'(s);
        exp_s1_pred.kind   = m_kind[s][idx];
        exp_s1_pred.target = m_target[s][idx];
      end
    end
  endtask

  // inputs are stable at the rising edge, writes land one edge after the update
  always @(posedge i_clk) begin
    if (!i_reset_n) begin
      for (int s = 0; s < SLOT_CNT; s++) begin
        for (int i = 0; i < BTB_ENTRIES; i++) begin
          m_valid[s][i] = 1'b0;
        end
      end
      pend_upd    = '0;
      exp_hit     = '0;
      exp_s1_pred = '0;
      exp_s2_pred = '0;
      armed       = 1'b0;
    end else begin
      exp_s2_pred = exp_s1_pred;
      predict_search(i_search);
      if (pend_upd.valid) begin
        apply_write(pend_upd);
      end
      pend_upd = i_upd;
      armed    = 1'b1;
    end
  end

  initial begin
    o_checks = 0;
    o_errors = 0;
  end

  // outputs are compared mid-cycle, away from the clock edge
  always @(negedge i_clk) begin
    if (armed) begin
      o_checks += 2;
      if (i_s1_hit !== exp_hit) begin
        o_errors++;
        $display("ERR %0t: o_s1_hit %b, expected %b", $time, i_s1_hit, exp_hit);
      end
      if (i_pred !== exp_s2_pred) begin
        o_errors++;
        $display("ERR %0t: o_pred v%0b h%0b slot %0d kind %0d target %h", $time,
                 i_pred.valid, i_pred.hit, i_pred.slot, i_pred.kind, i_pred.target);
        $display("ERR %0t: expected v%0b h%0b slot %0d kind %0d target %h", $time,
                 exp_s2_pred.valid, exp_s2_pred.hit, exp_s2_pred.slot,
                 exp_s2_pred.kind, exp_s2_pred.target);
      end
    end
  end

endmodule

// ==== dv/tb_bp_top.sv ====
`timescale 1ns/1ps

module tb_bp_top
  import bp_cfg_pkg::*;
  import bp_types_pkg::*;
();

  localparam int BTB_ENTRIES = 16;
  localparam int CLK_NS      = 10;
  localparam int N_DIRECTED  = 30;
  localparam int N_RANDOM    = 400;
  localparam int N_DRAIN     = 4;
  localparam int RUN_CYCLES  = 2 + N_DIRECTED + N_RANDOM + N_DRAIN;

  logic                clk;
  logic                reset_n;
  btb_update_t         upd;
  btb_search_t         search;
  logic [SLOT_CNT-1:0] s1_hit;
  bp_pred_t            pred;
  int                  checks;
  int                  errors;
  int                  seed = 27;

  bp_top #(
    .BTB_ENTRIES (BTB_ENTRIES),
    .SLOT_CNT    (SLOT_CNT)
  ) i_dut (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_upd     (upd),
    .i_search  (search),
    .o_s1_hit  (s1_hit),
    .o_pred    (pred)
  );

  bp_checker #(
    .BTB_ENTRIES (BTB_ENTRIES),
    .SLOT_CNT    (SLOT_CNT)
  ) u_checker (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_upd     (upd),
    .i_search  (search),
    .i_s1_hit  (s1_hit),
    .i_pred    (pred),
    .o_checks  (checks),
    .o_errors  (errors)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // small block pool where 0x1080 and 0x2008 alias 0x1000 and 0x1008 with other tags
  function automatic logic [VADDR_W-1:0] pool_block(input int k);
    case (k)
      0:       return 32'h0000_1000;
      1:       return 32'h0000_1008;
      2:       return 32'h0000_1010;
      3:       return 32'h0000_1078;
      4:       return 32'h0000_1080;
      default: return 32'h0000_2008;
    endcase
  endfunction

  function automatic logic [VADDR_W-1:0] rand_pc();
    logic [31:0] r;
    r = $random(seed);
    return pool_block(int'(r[7:0] % 8'd6)) + {29'd0, r[9:8], 1'b0};
  endfunction

  function automatic btb_update_t upd_of(input logic [VADDR_W-1:0] pc, input logic rvc,
                                         input br_kind_e kind,
                                         input logic [VADDR_W-1:0] target);
    btb_update_t u;
    u.valid  = 1'b1;
    u.pc     = pc;
    u.is_rvc = rvc;
    u.kind   = kind;
    u.target = target;
    return u;
  endfunction

  function automatic btb_search_t search_of(input logic [VADDR_W-1:0] pc);
    btb_search_t q;
    q.valid = 1'b1;
    q.pc    = pc;
    return q;
  endfunction

  task automatic drive_cycle(input btb_update_t u, input btb_search_t q);
    @(negedge clk);
    upd    = u;
    search = q;
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    btb_update_t u;
    btb_search_t q;
    logic [31:0] r;
    logic [31:0] tgt;
    clk     = 1'b0;
    reset_n = 1'b0;
    upd     = '0;
    search  = '0;
    repeat (2) @(negedge clk);
    reset_n = 1'b1;

    // empty buffer
    for (int k = 0; k < 6; k++) begin
      drive_cycle('0, search_of(pool_block(k) + 32'd2));
    end
    // compressed in slot 1, then two 4-byte branches, one crossing into 0x1008
    drive_cycle(upd_of(32'h1002, 1'b1, BR_CALL, 32'h4000), search_of(32'h1000));
    drive_cycle(upd_of(32'h1008, 1'b0, BR_JUMP, 32'h5000), search_of(32'h1000));
    drive_cycle(upd_of(32'h1006, 1'b0, BR_COND, 32'h6000), search_of(32'h1000));
    drive_cycle('0, search_of(32'h1008));
    drive_cycle('0, search_of(32'h1008));
    drive_cycle('0, search_of(32'h100A));
    drive_cycle(upd_of(32'h1006, 1'b1, BR_RET, 32'h7000), '0);
    drive_cycle('0, '0);
    drive_cycle('0, search_of(32'h1000));
    drive_cycle('0, search_of(32'h1004));
    // alias with another tag replaces slot 1 of index 0
    drive_cycle(upd_of(32'h1082, 1'b1, BR_JUMP, 32'h8000), search_of(32'h1000));
    drive_cycle('0, '0);
    drive_cycle('0, search_of(32'h1000));
    drive_cycle('0, search_of(32'h1080));

    for (int n = 0; n < N_RANDOM; n++) begin
      r = $random(seed);
      u = '0;
      q = '0;
      if (r[2:0] < 3'd3) begin
        tgt = $random(seed);
        u   = upd_of(rand_pc(), r[3], br_kind_e'(r[5:4]), tgt);
      end
      if (r[7:6] != 2'd0) begin
        q = search_of(rand_pc());
      end
      drive_cycle(u, q);
    end
    repeat (N_DRAIN) drive_cycle('0, '0);
    @(posedge clk);

    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, i_dut.u_asserts.fail_count);
    if (errors == 0 && i_dut.u_asserts.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_NS * 2);
    $display("watchdog expired before the stimulus finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/bp_cfg_pkg.sv
hdl/bp_types_pkg.sv
hdl/data_array_2p.sv
hdl/btb_update_decode.sv
hdl/btb_lookup.sv
hdl/fetch_target_select.sv
hdl/bp_top.sv
dv/bp_top_asserts.sv
dv/bp_checker.sv
dv/tb_bp_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bp_top -f sim.f -o Vtb_bp_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_bp_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
